// ==== rtl/sdmac_defs.svh ====
/* SCSI DMA controller constants
   FIFO sizing, strobe timing and the CPU register map */
`ifndef SDMAC_DEFS_SVH
`define SDMAC_DEFS_SVH

// Longword entries in the packing FIFO, also the bus-master credit count
`define SDMAC_FIFO_DEPTH 4

// Width of the byte count register
`define SDMAC_CNT_W 16

// Cycles the SCSI read strobe stays active
`define SDMAC_IO_CYCLES 2

// Register word addresses
`define SDMAC_REG_CTRL   3'd0
`define SDMAC_REG_BASE   3'd1
`define SDMAC_REG_COUNT  3'd2
`define SDMAC_REG_STATUS 3'd3

`endif

// ==== rtl/sdmacPkg.sv ====
/* SCSI DMA controller shared types
   Bundles passed between the register block, sequencers and packing FIFO */
`default_nettype none

`include "sdmac_defs.svh"

package sdmacPkg;

    // CPU register access
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [2:0]  addr;   // Word address
        logic [31:0] wdata;
    } cpuReqT;

    // Transfer setup seen by the datapath
    typedef struct packed {
        logic                    enable;
        logic [31:0]             base;   // Destination byte address
        logic [`SDMAC_CNT_W-1:0] count;  // Bytes to move
    } dmaCfgT;

    // One byte from the SCSI port
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       last;  // Final byte of the transfer
    } byteBeatT;

    // One packed longword, first byte in 31:24
    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic [3:0]  be;   // be[3] covers bits 31:24
    } lwordT;

endpackage

`default_nettype wire

// ==== rtl/dmacRegs.sv ====
/* DMA register block
   CTRL, BASE, COUNT and STATUS registers with done flag and interrupt */
`timescale 1ns/1ps
`default_nettype none

`include "sdmac_defs.svh"

module dmacRegs (
    input  wire                   nSCLK,
    input  wire                   arstN_i,
    input  wire sdmacPkg::cpuReqT cpuReq_i,
    output logic [31:0]           cpuRdData_o,
    input  wire                   lastWordDone_i,
    output sdmacPkg::dmaCfgT      cfg_o,
    output logic                  intr_o
);

    logic                    enable;
    logic                    intEn;
    logic                    done;
    logic                    busy;
    logic [31:0]             baseAddr;
    logic [`SDMAC_CNT_W-1:0] byteCount;
    logic                    wrEn;

    assign wrEn = cpuReq_i.valid & cpuReq_i.write;

    always_ff @(posedge nSCLK or negedge arstN_i) begin
        if (!arstN_i) begin
            enable    <= 1'b0;
            intEn     <= 1'b0;
            done      <= 1'b0;
            busy      <= 1'b0;
            baseAddr  <= '0;
            byteCount <= '0;
        end else begin
            if (wrEn) begin
                case (cpuReq_i.addr)
                    `SDMAC_REG_CTRL: begin
                        enable <= cpuReq_i.wdata[0];
                        intEn  <= cpuReq_i.wdata[1];
                        if (cpuReq_i.wdata[0]) begin  // Start of a transfer
                            done <= 1'b0;
                            busy <= 1'b1;
                        end
                    end
                    `SDMAC_REG_BASE:   baseAddr  <= cpuReq_i.wdata;
                    `SDMAC_REG_COUNT:  byteCount <= cpuReq_i.wdata[`SDMAC_CNT_W-1:0];
                    `SDMAC_REG_STATUS: if (cpuReq_i.wdata[0]) done <= 1'b0;  // W1C
                    default: ;
                endcase
            end
            // Completion wins, enable must be rewritten for the next run
            if (lastWordDone_i) begin
                done   <= 1'b1;
                busy   <= 1'b0;
                enable <= 1'b0;
            end
        end
    end

    always_comb begin
        cpuRdData_o = 32'h0;
        if (cpuReq_i.valid && !cpuReq_i.write) begin
            case (cpuReq_i.addr)
                `SDMAC_REG_CTRL:   cpuRdData_o = {30'h0, intEn, enable};
                `SDMAC_REG_BASE:   cpuRdData_o = baseAddr;
                `SDMAC_REG_COUNT:  cpuRdData_o = {{(32-`SDMAC_CNT_W){1'b0}}, byteCount};
                `SDMAC_REG_STATUS: cpuRdData_o = {30'h0, busy, done};
                default:           cpuRdData_o = 32'h0;
            endcase
        end
    end

    assign cfg_o.enable = enable;
    assign cfg_o.base   = baseAddr;
    assign cfg_o.count  = byteCount;

    assign intr_o = done & intEn;

endmodule

`default_nettype wire

// ==== rtl/scsiPortSm.sv ====
/* SCSI peripheral port sequencer
   Answers DREQ with DACK and read strobe, forwards bytes on a credit budget */
`timescale 1ns/1ps
`default_nettype none

`include "sdmac_defs.svh"

module scsiPortSm (
    input  wire                   nSCLK,
    input  wire                   arstN_i,
    input  wire sdmacPkg::dmaCfgT cfg_i,
    input  wire                   scsiDreq_i,
    input  wire [7:0]             scsiData_i,
    output logic                  scsiDack_o,
    output logic                  scsiRd_o,
    output sdmacPkg::byteBeatT    beat_o,
    input  wire                   byteCredit_i
);

    typedef enum logic [1:0] {sIdle, sStrobe, sRecover} stateT;

    localparam int IO_W    = $clog2(`SDMAC_IO_CYCLES + 1);
    localparam int CREDITS = 4;  // One per packing lane

    stateT                   state;
    logic [IO_W-1:0]         ioCnt;
    logic [`SDMAC_CNT_W-1:0] remaining;
    logic [2:0]              credits;
    logic                    enD;
    logic                    startOk;
    logic                    lastStrobe;

    // enD keeps the first enabled cycle out, remaining is loaded then
    assign startOk = cfg_i.enable & enD & (remaining != '0) & scsiDreq_i & (credits != 3'd0);
    assign lastStrobe = (state == sStrobe) && (ioCnt == IO_W'(`SDMAC_IO_CYCLES - 1));

    always_ff @(posedge nSCLK or negedge arstN_i) begin
        if (!arstN_i) begin
            state     <= sIdle;
            ioCnt     <= '0;
            remaining <= '0;
            credits   <= 3'(CREDITS);
            enD       <= 1'b0;
            beat_o    <= '0;
        end else begin
            enD          <= cfg_i.enable;
            beat_o.valid <= 1'b0;
            credits      <= credits + {2'b0, byteCredit_i} - {2'b0, lastStrobe};
            if (cfg_i.enable && !enD)
                remaining <= cfg_i.count;  // Enable rising edge
            case (state)
                sIdle: begin
                    ioCnt <= '0;
                    if (startOk) state <= sStrobe;
                end
                sStrobe: begin
                    if (lastStrobe) begin
                        state        <= sRecover;
                        ioCnt        <= '0;
                        beat_o.valid <= 1'b1;
                        beat_o.data  <= scsiData_i;
                        beat_o.last  <= (remaining == `SDMAC_CNT_W'(1));
                        remaining    <= remaining - 1'b1;
                    end else begin
                        ioCnt <= ioCnt + 1'b1;
                    end
                end
                sRecover: state <= startOk ? sStrobe : sIdle;  // One quiet cycle
                default: state <= sIdle;
            endcase
        end
    end

    assign scsiDack_o = (state == sStrobe);
    assign scsiRd_o   = (state == sStrobe);

endmodule

`default_nettype wire

// ==== rtl/packFifo.sv ====
/* Byte to longword packer with a longword ring buffer
   Big-endian lane fill, byte credits back to the sequencer, word credits in */
`timescale 1ns/1ps
`default_nettype none

`include "sdmac_defs.svh"

module packFifo (
    input  wire                     nSCLK,
    input  wire                     arstN_i,
    input  wire sdmacPkg::byteBeatT beat_i,
    output logic                    byteCredit_o,
    input  wire                     wordPop_i,
    output sdmacPkg::lwordT         word_o,
    input  wire                     wordCredit_i
);

    localparam int DEPTH = `SDMAC_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [31:0]      packData;
    logic [3:0]       packBe;
    logic [1:0]       lanePtr;
    logic             packFull;    // Word closed, waiting for a slot
    logic [2:0]       packBytes;
    logic [2:0]       creditPend;  // Byte credits still owed
    logic [31:0]      memData [DEPTH];
    logic [3:0]       memBe [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] availCnt;    // Pushed, not yet popped
    logic [CNT_W-1:0] usedCnt;     // Pushed, not yet freed
    logic             push;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign push = packFull && (usedCnt < CNT_W'(DEPTH));

    // Lane data, first byte of a word clears the lower lanes
    always_ff @(posedge nSCLK) begin
        if (beat_i.valid) begin
            if (lanePtr == 2'd0)
                packData <= {beat_i.data, 24'h0};
            else
                packData[8*(3-lanePtr) +: 8] <= beat_i.data;
        end
    end

    always_ff @(posedge nSCLK or negedge arstN_i) begin
        if (!arstN_i) begin
            lanePtr    <= '0;
            packFull   <= 1'b0;
            packBe     <= '0;
            packBytes  <= '0;
            creditPend <= '0;
        end else begin
            creditPend <= creditPend - {2'b0, creditPend != 3'd0} + (push ? packBytes : 3'd0);
            if (push)
                packFull <= 1'b0;
            if (beat_i.valid) begin
                lanePtr <= lanePtr + 1'b1;
                if (lanePtr == 2'd3 || beat_i.last) begin  // Full or tail word
                    packFull  <= 1'b1;
                    packBe    <= 4'hf << (2'd3 - lanePtr);
                    packBytes <= {1'b0, lanePtr} + 3'd1;
                    lanePtr   <= '0;
                end
            end
        end
    end

    assign byteCredit_o = (creditPend != 3'd0);

    always_ff @(posedge nSCLK) begin
        if (push) begin
            memData[wrPtr] <= packData;
            memBe[wrPtr]   <= packBe;
        end
    end

    always_ff @(posedge nSCLK or negedge arstN_i) begin
        if (!arstN_i) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            availCnt <= '0;
            usedCnt  <= '0;
        end else begin
            if (push)
                wrPtr <= nextPtr(wrPtr);
            if (wordPop_i)
                rdPtr <= nextPtr(rdPtr);
            availCnt <= availCnt + CNT_W'(push) - CNT_W'(wordPop_i);
            usedCnt  <= usedCnt + CNT_W'(push) - CNT_W'(wordCredit_i);  // Freed on bus ack
        end
    end

    assign word_o.valid = (availCnt != '0);
    assign word_o.data  = memData[rdPtr];
    assign word_o.be    = memBe[rdPtr];

endmodule

`default_nettype wire

// ==== rtl/busMasterSm.sv ====
/* System bus master
   Requests the bus and writes FIFO longwords to memory at rising addresses */
`timescale 1ns/1ps
`default_nettype none

`include "sdmac_defs.svh"

module busMasterSm (
    input  wire                   nSCLK,
    input  wire                   arstN_i,
    input  wire sdmacPkg::dmaCfgT cfg_i,
    input  wire sdmacPkg::lwordT  word_i,
    output logic                  wordPop_o,
    output logic                  wordCredit_o,
    output logic                  busReq_o,
    input  wire                   busGnt_i,
    output logic [31:0]           busAddr_o,
    output logic [31:0]           busData_o,
    output logic [3:0]            busBe_o,
    output logic                  busWr_o,
    input  wire                   busAck_i,
    output logic                  lastWordDone_o
);

    typedef enum logic [1:0] {sIdle, sRequest, sWrite, sRelease} stateT;

    localparam int CR_W = $clog2(`SDMAC_FIFO_DEPTH + 1);
    localparam int BC_W = `SDMAC_CNT_W + 1;

    stateT           state;
    logic [CR_W-1:0] credits;
    logic [31:0]     dataQ;
    logic [3:0]      beQ;
    logic [BC_W-1:0] bytesDone;
    logic [BC_W-1:0] bytesNext;
    logic [2:0]      beBytes;
    logic            enD;
    logic            canPop;
    logic            ackNow;

    assign canPop = word_i.valid && (credits != '0) && busGnt_i;
    assign ackNow = (state == sWrite) && busAck_i;

    always_comb begin
        wordPop_o = 1'b0;
        case (state)
            sRequest: wordPop_o = canPop;
            sWrite:   wordPop_o = busAck_i && canPop;  // Back-to-back write
            sRelease: wordPop_o = canPop;
            default:  wordPop_o = 1'b0;
        endcase
    end

    assign beBytes   = {2'b0, beQ[3]} + {2'b0, beQ[2]} + {2'b0, beQ[1]} + {2'b0, beQ[0]};
    assign bytesNext = bytesDone + BC_W'(beBytes);

    // Tail word or the byte count reached
    assign lastWordDone_o = ackNow && ((beQ != 4'hf) || (bytesNext >= BC_W'(cfg_i.count)));
    assign wordCredit_o   = ackNow;

    always_ff @(posedge nSCLK) begin
        if (wordPop_o) begin
            dataQ <= word_i.data;
            beQ   <= word_i.be;
        end
    end

    always_ff @(posedge nSCLK or negedge arstN_i) begin
        if (!arstN_i) begin
            state     <= sIdle;
            credits   <= CR_W'(`SDMAC_FIFO_DEPTH);
            busAddr_o <= '0;
            bytesDone <= '0;
            enD       <= 1'b0;
        end else begin
            enD     <= cfg_i.enable;
            credits <= credits - CR_W'(wordPop_o) + CR_W'(ackNow);
            if (cfg_i.enable && !enD) begin  // New transfer
                busAddr_o <= cfg_i.base;
                bytesDone <= '0;
            end else if (ackNow) begin
                busAddr_o <= busAddr_o + 32'd4;
                bytesDone <= bytesNext;
            end
            case (state)
                sIdle:    if (word_i.valid) state <= sRequest;
                sRequest: if (wordPop_o) state <= sWrite;
                sWrite:   if (busAck_i) state <= wordPop_o ? sWrite : sRelease;
                sRelease: state <= wordPop_o ? sWrite : sIdle;  // Hold request one cycle
                default:  state <= sIdle;
            endcase
        end
    end

    assign busReq_o  = (state != sIdle);
    assign busWr_o   = (state == sWrite);
    assign busData_o = dataQ;
    assign busBe_o   = beQ;

endmodule

`default_nettype wire

// ==== rtl/sdmacTop.sv ====
/* SCSI DMA controller top level
   Registers, SCSI port sequencer, packing FIFO and bus master */
`timescale 1ns/1ps
`default_nettype none

module sdmacTop (
    input  wire                   nSCLK,
    input  wire                   arstN_i,
    input  wire sdmacPkg::cpuReqT cpuReq_i,
    output wire [31:0]            cpuRdData_o,
    output wire                   intr_o,
    input  wire                   scsiDreq_i,
    input  wire [7:0]             scsiData_i,
    output wire                   scsiDack_o,
    output wire                   scsiRd_o,
    output wire                   busReq_o,
    input  wire                   busGnt_i,
    output wire [31:0]            busAddr_o,
    output wire [31:0]            busData_o,
    output wire [3:0]             busBe_o,
    output wire                   busWr_o,
    input  wire                   busAck_i
);

    sdmacPkg::dmaCfgT   cfg;
    sdmacPkg::byteBeatT beat;
    sdmacPkg::lwordT    word;
    wire                byteCredit;
    wire                wordPop;
    wire                wordCredit;
    wire                lastWordDone;

    dmacRegs uRegs (
        .nSCLK          (nSCLK),
        .arstN_i        (arstN_i),
        .cpuReq_i       (cpuReq_i),
        .cpuRdData_o    (cpuRdData_o),
        .lastWordDone_i (lastWordDone),
        .cfg_o          (cfg),
        .intr_o         (intr_o)
    );

    scsiPortSm uScsi (
        .nSCLK        (nSCLK),
        .arstN_i      (arstN_i),
        .cfg_i        (cfg),
        .scsiDreq_i   (scsiDreq_i),
        .scsiData_i   (scsiData_i),
        .scsiDack_o   (scsiDack_o),
        .scsiRd_o     (scsiRd_o),
        .beat_o       (beat),
        .byteCredit_i (byteCredit)
    );

    packFifo uFifo (
        .nSCLK        (nSCLK),
        .arstN_i      (arstN_i),
        .beat_i       (beat),
        .byteCredit_o (byteCredit),
        .wordPop_i    (wordPop),
        .word_o       (word),
        .wordCredit_i (wordCredit)
    );

    busMasterSm uBus (
        .nSCLK          (nSCLK),
        .arstN_i        (arstN_i),
        .cfg_i          (cfg),
        .word_i         (word),
        .wordPop_o      (wordPop),
        .wordCredit_o   (wordCredit),
        .busReq_o       (busReq_o),
        .busGnt_i       (busGnt_i),
        .busAddr_o      (busAddr_o),
        .busData_o      (busData_o),
        .busBe_o        (busBe_o),
        .busWr_o        (busWr_o),
        .busAck_i       (busAck_i),
        .lastWordDone_o (lastWordDone)
    );

endmodule

`default_nettype wire

// ==== dv/sdmacChecker.sv ====
/* DMA checker
   Predicts register reads, interrupt and every memory write, and counts mismatches */
`timescale 1ns/1ps
`default_nettype none

`include "sdmac_defs.svh"

module sdmacChecker (
    input  wire                   nSCLK,
    input  wire                   arstN_i,
    input  wire sdmacPkg::cpuReqT cpuReq_i,
    input  wire [31:0]            cpuRdData_i,
    input  wire                   intr_i,
    input  wire                   scsiDack_i,
    input  wire                   scsiRd_i,
    input  wire                   busReq_i,
    input  wire                   busWr_i,
    input  wire [31:0]            busAddr_i,
    input  wire [31:0]            busData_i,
    input  wire [3:0]             busBe_i,
    input  wire                   busAck_i,
    output int                    errCount_o
);

    logic [7:0]              expBytes [$];  // Bytes the SCSI model hands over
    logic                    en;
    logic                    intEn;
    logic                    done;
    logic                    busy;
    logic [31:0]             base;
    logic [`SDMAC_CNT_W-1:0] count;
    logic                    dackPrev;
    logic                    reqPrev;
    logic                    pending;       // Write seen and not yet acked
    logic [31:0]             heldAddr;
    logic [31:0]             heldData;
    logic [3:0]              heldBe;
    int                      wrIdx;
    int                      dackCnt;
    int                      errors = 0;

    assign errCount_o = errors;

    task automatic addByte(input logic [7:0] b);
        expBytes.push_back(b);
    endtask

    task automatic flagError(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        errors++;
    endtask

    function automatic logic [31:0] expectedRead(input logic [2:0] addr);
        case (addr)
            `SDMAC_REG_CTRL:   return {30'h0, intEn, en};
            `SDMAC_REG_BASE:   return base;
            `SDMAC_REG_COUNT:  return 32'(count);
            `SDMAC_REG_STATUS: return {30'h0, busy, done};
            default:           return 32'h0;
        endcase
    endfunction

    // Big-endian lanes with the first byte of the word in 31:24
    task automatic wordFor(input int idx, output logic [31:0] data, output logic [3:0] be);
        int pos;
        data = '0;
        be   = '0;
        for (int k = 0; k < 4; k++) begin
            pos = 4 * idx + k;
            if (pos < int'(count) && pos < expBytes.size()) begin
                be[3-k]            = 1'b1;
                data[8*(3-k) +: 8] = expBytes[pos];
            end
        end
    endtask

    always @(posedge nSCLK) begin : watch
        logic [31:0] expData;
        logic [3:0]  expBe;
        logic [31:0] mask;
        if (!arstN_i) begin
            if (busReq_i || busWr_i || scsiDack_i || scsiRd_i || intr_i)
                flagError("output active during reset");
            en       = 1'b0;
            intEn    = 1'b0;
            done     = 1'b0;
            busy     = 1'b0;
            base     = '0;
            count    = '0;
            dackPrev = 1'b0;
            reqPrev  = 1'b0;
            pending  = 1'b0;
            wrIdx    = 0;
            dackCnt  = 0;
            expBytes.delete();
        end else begin
            if (cpuReq_i.valid && !cpuReq_i.write &&
                cpuRdData_i !== expectedRead(cpuReq_i.addr))
                flagError($sformatf("register %0d read %h, expected %h", cpuReq_i.addr,
                                    cpuRdData_i, expectedRead(cpuReq_i.addr)));
            if (intr_i !== (done & intEn))
                flagError($sformatf("intr_o is %b, expected %b", intr_i, done & intEn));
            if (scsiRd_i !== scsiDack_i)
                flagError($sformatf("scsiRd is %b while scsiDack is %b", scsiRd_i, scsiDack_i));
            if (busReq_i && !reqPrev && !busy)
                flagError("busReq raised outside a transfer");
            if (scsiDack_i && !dackPrev) begin
                dackCnt++;
                if (dackCnt > int'(count))
                    flagError("scsiDack rose after the last byte");
            end
            if (pending && (!busWr_i || busAddr_i !== heldAddr || busData_i !== heldData ||
                            busBe_i !== heldBe))
                flagError("bus write changed before busAck");
            if (busWr_i && !pending) begin  // New write cycle
                wordFor(wrIdx, expData, expBe);
                mask = {{8{expBe[3]}}, {8{expBe[2]}}, {8{expBe[1]}}, {8{expBe[0]}}};
                if (4 * wrIdx >= int'(count))
                    flagError($sformatf("write %0d beyond the byte count", wrIdx));
                else if (busAddr_i !== base + 32'(4 * wrIdx) || busBe_i !== expBe ||
                         (busData_i & mask) !== (expData & mask))
                    flagError($sformatf("write %0d got %h/%h/%h, expected %h/%h/%h", wrIdx,
                                        busAddr_i, busData_i, busBe_i,
                                        base + 32'(4 * wrIdx), expData, expBe));
                heldAddr = busAddr_i;
                heldData = busData_i;
                heldBe   = busBe_i;
            end
            pending = busWr_i && !busAck_i;
            if (cpuReq_i.valid && cpuReq_i.write) begin
                case (cpuReq_i.addr)
                    `SDMAC_REG_CTRL: begin
                        en    = cpuReq_i.wdata[0];
                        intEn = cpuReq_i.wdata[1];
                        if (cpuReq_i.wdata[0]) begin  // Transfer start
                            done    = 1'b0;
                            busy    = 1'b1;
                            wrIdx   = 0;
                            dackCnt = 0;
                        end
                    end
                    `SDMAC_REG_BASE:   base  = cpuReq_i.wdata;
                    `SDMAC_REG_COUNT:  count = cpuReq_i.wdata[`SDMAC_CNT_W-1:0];
                    `SDMAC_REG_STATUS: if (cpuReq_i.wdata[0]) done = 1'b0;
                    default: ;
                endcase
            end
            if (busWr_i && busAck_i) begin
                wrIdx++;
                if (4 * wrIdx >= int'(count)) begin  // Last byte written
                    done = 1'b1;
                    busy = 1'b0;
                    en   = 1'b0;
                    expBytes.delete();
                end
            end
            dackPrev = scsiDack_i;
            reqPrev  = busReq_i;
        end
    end

endmodule

`default_nettype wire

// ==== dv/sdmacTb.sv ====
/* SCSI DMA controller testbench
   Clock, reset, CPU access, SCSI chip and memory models, test sequence and timeout */
`timescale 1ns/1ps
`default_nettype none

`include "sdmac_defs.svh"

module sdmacTb;

    localparam int PERIOD      = 100;
    // Byte counts of tests 2 to 6 at 24 cycles each plus 200 per test
    localparam int CYCLE_LIMIT = 24 * (64 + 18 + 40 + 21 + 20) + 6 * 200;

    logic             nSCLK;
    logic             arstN;
    sdmacPkg::cpuReqT cpuReq;
    logic             scsiDreq = 1'b0;
    logic [7:0]       scsiData = 8'h00;
    logic             busGnt   = 1'b0;
    logic             busAck   = 1'b0;
    wire  [31:0]      cpuRdData;
    wire              intr;
    wire              scsiDack;
    wire              scsiRd;
    wire              busReq;
    wire              busWr;
    wire  [31:0]      busAddr;
    wire  [31:0]      busData;
    wire  [3:0]       busBe;
    int               errCount;
    integer           seed = 32'h1b83;
    logic [7:0]       srcQ [$];      // Bytes still inside the SCSI chip
    logic             dackSeen = 1'b0;
    int               gntMax = 3;    // Grant delay bound
    int               ackMax = 3;    // Ack latency bound
    int               gntWait = 0;
    int               ackWait = 0;
    int               cycles;
    int               testsRun = 0;
    int               testsPassed = 0;
    int               errAtStart = 0;
    logic [31:0]      rd;

    sdmacTop dut (
        .nSCLK(nSCLK), .arstN_i(arstN), .cpuReq_i(cpuReq), .cpuRdData_o(cpuRdData),
        .intr_o(intr), .scsiDreq_i(scsiDreq), .scsiData_i(scsiData), .scsiDack_o(scsiDack),
        .scsiRd_o(scsiRd), .busReq_o(busReq), .busGnt_i(busGnt), .busAddr_o(busAddr),
        .busData_o(busData), .busBe_o(busBe), .busWr_o(busWr), .busAck_i(busAck)
    );

    sdmacChecker chk (
        .nSCLK(nSCLK), .arstN_i(arstN), .cpuReq_i(cpuReq), .cpuRdData_i(cpuRdData),
        .intr_i(intr), .scsiDack_i(scsiDack), .scsiRd_i(scsiRd), .busReq_i(busReq),
        .busWr_i(busWr), .busAddr_i(busAddr), .busData_i(busData), .busBe_i(busBe),
        .busAck_i(busAck), .errCount_o(errCount)
    );

    initial begin
        nSCLK = 1'b0;
        forever #(PERIOD / 2) nSCLK = ~nSCLK;
    end

    function automatic int randBelow(input int n);
        return {$random(seed)} % n;
    endfunction

    function automatic logic [31:0] randAddr();
        return $random(seed) & 32'hffff_fffc;  // Longword aligned
    endfunction

    // SCSI chip model that drops a byte once its strobe has ended
    always @(negedge nSCLK) begin
        if (dackSeen && !scsiDack && srcQ.size() != 0)
            void'(srcQ.pop_front());
        dackSeen = scsiDack;
        scsiData = (srcQ.size() != 0) ? srcQ[0] : 8'h00;
        scsiDreq = arstN && (srcQ.size() != 0) && (randBelow(4) != 0);
    end

    // Memory side with random grant delay and ack latency
    always @(negedge nSCLK) begin
        if (!arstN || !busReq) begin
            busGnt  = 1'b0;
            gntWait = randBelow(gntMax + 1);
        end else if (gntWait != 0)
            gntWait--;
        else
            busGnt = 1'b1;
        if (arstN && busWr && !busAck) begin
            if (ackWait == 0)
                busAck = 1'b1;
            else
                ackWait--;
        end else begin
            busAck  = 1'b0;
            ackWait = randBelow(ackMax + 1);
        end
    end

    task automatic holdReset();
        arstN = 1'b0;
        repeat (5) @(negedge nSCLK);
        arstN = 1'b1;
        @(negedge nSCLK);
    endtask

    task automatic writeReg(input logic [2:0] addr, input logic [31:0] data);
        cpuReq.valid = 1'b1;
        cpuReq.write = 1'b1;
        cpuReq.addr  = addr;
        cpuReq.wdata = data;
        @(negedge nSCLK);
        cpuReq = '0;
    endtask

    task automatic readReg(input logic [2:0] addr, output logic [31:0] data);
        cpuReq.valid = 1'b1;
        cpuReq.write = 1'b0;
        cpuReq.addr  = addr;
        cpuReq.wdata = '0;
        @(posedge nSCLK);
        data = cpuRdData;
        @(negedge nSCLK);
        cpuReq = '0;
    endtask

    task automatic startTransfer(input logic [31:0] base, input logic [15:0] count,
                                 input logic intEn);
        logic [7:0] b;
        for (int i = 0; i < int'(count); i++) begin
            b = 8'(randBelow(256));
            srcQ.push_back(b);
            chk.addByte(b);
        end
        writeReg(`SDMAC_REG_BASE, base);
        writeReg(`SDMAC_REG_COUNT, 32'(count));
        writeReg(`SDMAC_REG_CTRL, {30'h0, intEn, 1'b1});
    endtask

    task automatic runTransfer(input logic [31:0] base, input logic [15:0] count,
                               input logic intEn);
        logic [31:0] st;
        st = '0;
        startTransfer(base, count, intEn);
        while (!st[0])
            readReg(`SDMAC_REG_STATUS, st);  // Poll done
    endtask

    task automatic endTest(input int num, input string name);
        testsRun++;
        if (errCount == errAtStart) begin
            testsPassed++;
            $display("Test %0d %s: passed", num, name);
        end else
            $display("Test %0d %s: %0d errors", num, name, errCount - errAtStart);
        errAtStart = errCount;
    endtask

    initial begin
        arstN  = 1'b0;
        cpuReq = '0;
        holdReset();

        for (int a = 0; a < 4; a++)
            readReg(3'(a), rd);
        writeReg(`SDMAC_REG_BASE, 32'h0004_1230);
        writeReg(`SDMAC_REG_COUNT, 32'h0000_0123);
        readReg(`SDMAC_REG_BASE, rd);
        readReg(`SDMAC_REG_COUNT, rd);
        endTest(1, "register access");

        runTransfer(randAddr(), 16'd64, 1'b0);
        endTest(2, "full longwords");

        for (int n = 5; n <= 7; n++)
            runTransfer(randAddr(), 16'(n), 1'b0);
        endTest(3, "partial tail");

        gntMax = 7;
        ackMax = 7;
        runTransfer(randAddr(), 16'd40, 1'b0);
        gntMax = 3;
        ackMax = 3;
        endTest(4, "back-pressure");

        runTransfer(randAddr(), 16'd12, 1'b1);
        readReg(`SDMAC_REG_STATUS, rd);
        writeReg(`SDMAC_REG_STATUS, 32'h1);  // Clear done
        readReg(`SDMAC_REG_STATUS, rd);
        runTransfer(randAddr(), 16'd9, 1'b0);
        writeReg(`SDMAC_REG_STATUS, 32'h1);
        endTest(5, "completion and interrupt");

        runTransfer(randAddr(), 16'd4, 1'b1);  // Leaves done and intr_o high
        holdReset();
        startTransfer(randAddr(), 16'd16, 1'b1);
        while (!busWr)
            @(negedge nSCLK);
        srcQ.delete();
        holdReset();  // Reset in the middle of a write
        for (int a = 0; a < 4; a++)
            readReg(3'(a), rd);
        endTest(6, "reset");

        $display("Summary: %0d tests run, %0d passed, %0d check errors",
                 testsRun, testsPassed, errCount);
        if (errCount == 0 && testsPassed == testsRun)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge nSCLK);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sdmacTop.f ====
+incdir+rtl
rtl/sdmacPkg.sv
rtl/dmacRegs.sv
rtl/scsiPortSm.sv
rtl/packFifo.sv
rtl/busMasterSm.sv
rtl/sdmacTop.sv
dv/sdmacChecker.sv
dv/sdmacTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the SCSI DMA testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module sdmacTb -f sdmacTop.f -o sdmacSim &&
    simOut=$(./obj_dir/sdmacSim)
printf '%s\n' "$simOut"
printf '%s\n' "$simOut" | grep -qx "TEST OK" && echo "Simulation passed" ||
    { echo "Simulation failed"; exit 1; }
